// ==== hdl/glm_defines.svh ====
`ifndef GLM_DEFINES_SVH
`define GLM_DEFINES_SVH

// Width of one model line and of one host cache line
`define GLM_LINE_BITS 512

// Host line address and line count widths
`define GLM_ADDR_BITS 42
`define GLM_LEN_BITS 16

// On-chip model memory geometry
`define GLM_MODEL_DEPTH 64
`define GLM_MODEL_IDX_BITS 6

// FIFO size and the fill level where almost-full rises
`define GLM_FIFO_DEPTH 8
`define GLM_FIFO_AFULL 5

`endif

// ==== hdl/glm_pkg.sv ====
`default_nettype none

`include "glm_defines.svh"

package glm_pkg;

    typedef logic [`GLM_LINE_BITS-1:0] line_t;
    typedef logic [`GLM_ADDR_BITS-1:0] addr_t;
    typedef logic [`GLM_LEN_BITS-1:0] len_t;
    typedef logic [`GLM_MODEL_IDX_BITS-1:0] model_idx_t;

    // Bit 31 of offset picks in_addr when set, out_addr when clear
    typedef struct packed
    {
        addr_t in_addr;
        addr_t out_addr;
        logic [31:0] offset;
        len_t length;
        model_idx_t model_start;
    } store_cmd_t;

    typedef struct packed
    {
        addr_t addr;
        line_t data;
    } wr_req_t;

    // Run description handed from the controller to the reader
    typedef struct packed
    {
        model_idx_t model_start;
        len_t length;
    } run_cfg_t;

endpackage

`default_nettype wire

// ==== hdl/model_bram.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "glm_defines.svh"

module model_bram
    import glm_pkg::*;
(
    input  logic clk,

    // Load port, one model line per cycle
    input  logic load_en,
    input  model_idx_t load_idx,
    input  line_t load_data,

    // Read port with one cycle of latency
    input  logic rd_en,
    input  model_idx_t rd_idx,
    output line_t rd_data
);

    line_t mem [`GLM_MODEL_DEPTH];

    always_ff @(posedge clk)
    begin
        if (load_en)
        begin
            mem[load_idx] <= load_data;
        end
    end

    // The output register holds its value between reads
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/line_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "glm_defines.svh"

module line_fifo
    import glm_pkg::*;
#(
    parameter type payload_t = line_t
)
(
    input  logic clk,
    input  logic reset,

    input  logic push,
    input  payload_t push_data,

    input  logic pop,
    output payload_t pop_data,

    output logic empty,
    output logic alm_full
);

    localparam int PTR_BITS = $clog2(`GLM_FIFO_DEPTH);

    payload_t mem [`GLM_FIFO_DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0] count;

    logic do_push;
    logic do_pop;

    // A push into a full FIFO or a pop from an empty one is dropped
    assign do_push = push && (count != (PTR_BITS+1)'(`GLM_FIFO_DEPTH));
    assign do_pop = pop && !empty;

    assign empty = (count == '0);
    assign alm_full = (count >= (PTR_BITS+1)'(`GLM_FIFO_AFULL));

    // Head entry is visible one cycle after it was pushed
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + do_push - do_pop;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bram_line_reader.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "glm_defines.svh"

module bram_line_reader
    import glm_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic run_go,
    input  run_cfg_t run_cfg,

    // Almost-full of the line FIFO
    input  logic stall,

    output logic rd_en,
    output model_idx_t rd_idx,
    output logic rd_valid
);

    model_idx_t next_idx;
    len_t remaining;

    // One read per cycle while lines remain and the FIFO has room
    assign rd_en = (remaining != '0) && !stall;
    assign rd_idx = next_idx;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            remaining <= '0;
            rd_valid <= 1'b0;
        end
        else
        begin
            // Data leaves the memory one cycle after the read
            rd_valid <= rd_en;

            if (run_go)
            begin
                remaining <= run_cfg.length;
            end
            else if (rd_en)
            begin
                remaining <= remaining - `GLM_LEN_BITS'(1);
            end
        end
    end

    // The index wraps around the model memory
    always_ff @(posedge clk)
    begin
        if (run_go)
        begin
            next_idx <= run_cfg.model_start;
        end
        else if (rd_en)
        begin
            next_idx <= next_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/store_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "glm_defines.svh"

module store_controller
    import glm_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic op_start,
    input  store_cmd_t cmd,

    // One pulse per acknowledged host write
    input  logic wr_ack,

    output logic run_go,
    output run_cfg_t run_cfg,
    output logic sender_go,
    output addr_t base_addr,
    output logic op_done
);

    typedef enum logic [1:0]
    {
        STATE_IDLE,
        STATE_RUN,
        STATE_DONE
    } state_t;

    state_t state;
    len_t ack_count;

    addr_t sel_base;
    addr_t offset_ext;

    // Offset bit 31 doubles as base select and as the sign of the offset
    assign sel_base = cmd.offset[31] ? cmd.in_addr : cmd.out_addr;
    assign offset_ext = {{(`GLM_ADDR_BITS-32){cmd.offset[31]}}, cmd.offset};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= STATE_IDLE;
            ack_count <= '0;
            run_go <= 1'b0;
            sender_go <= 1'b0;
            op_done <= 1'b0;
        end
        else
        begin
            run_go <= 1'b0;
            sender_go <= 1'b0;
            op_done <= 1'b0;

            case (state)
                STATE_IDLE:
                begin
                    if (op_start)
                    begin
                        ack_count <= '0;
                        if (cmd.length == '0)
                        begin
                            state <= STATE_DONE;
                        end
                        else
                        begin
                            state <= STATE_RUN;
                            run_go <= 1'b1;
                            sender_go <= 1'b1;
                        end
                    end
                end

                STATE_RUN:
                begin
                    // op_start is not looked at here, so a second command is dropped
                    if (wr_ack)
                    begin
                        ack_count <= ack_count + 1'b1;
                        if (ack_count == run_cfg.length - 1'b1)
                        begin
                            op_done <= 1'b1;
                            state <= STATE_IDLE;
                        end
                    end
                end

                STATE_DONE:
                begin
                    op_done <= 1'b1;
                    state <= STATE_IDLE;
                end

                default:
                begin
                    state <= STATE_IDLE;
                end
            endcase
        end
    end

    // Command fields are captured once per accepted command
    always_ff @(posedge clk)
    begin
        if ((state == STATE_IDLE) && op_start)
        begin
            run_cfg.model_start <= cmd.model_start;
            run_cfg.length <= cmd.length;
            base_addr <= sel_base + offset_ext;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/write_sender.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "glm_defines.svh"

module write_sender
    import glm_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic sender_go,
    input  addr_t base_addr,

    // Line FIFO side
    input  logic line_empty,
    input  line_t line_data,
    output logic line_pop,

    // Request FIFO side
    input  logic req_alm_full,
    output logic req_push,
    output wr_req_t req
);

    len_t seq;

    // Move a line whenever one is waiting and the request FIFO has room
    assign line_pop = !line_empty && !req_alm_full;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            seq <= '0;
            req_push <= 1'b0;
        end
        else
        begin
            req_push <= line_pop;
            if (sender_go)
            begin
                seq <= '0;
            end
            else if (line_pop)
            begin
                seq <= seq + 1'b1;
            end
        end
    end

    // Request i goes to base plus i
    always_ff @(posedge clk)
    begin
        if (line_pop)
        begin
            req.addr <= base_addr + {{(`GLM_ADDR_BITS-`GLM_LEN_BITS){1'b0}}, seq};
            req.data <= line_data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/glm_store_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "glm_defines.svh"

module glm_store_top
    import glm_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic op_start,
    input  store_cmd_t cmd,
    output logic op_done,

    input  logic load_en,
    input  model_idx_t load_idx,
    input  line_t load_data,

    // Posted host writes, accepted whenever wr_valid is high
    output logic wr_valid,
    output wr_req_t wr_req,
    input  logic host_alm_full,
    input  logic wr_ack
);

    logic run_go;
    run_cfg_t run_cfg;
    logic sender_go;
    addr_t base_addr;

    logic rd_en;
    model_idx_t rd_idx;
    logic rd_valid;
    line_t rd_data;

    logic line_empty;
    logic line_alm_full;
    logic line_pop;
    line_t line_data;

    logic req_push;
    wr_req_t req;
    logic req_empty;
    logic req_alm_full;
    logic req_pop;
    wr_req_t req_head;

    store_controller store_controller_i (
        .clk, .reset,
        .op_start, .cmd, .wr_ack,
        .run_go, .run_cfg, .sender_go, .base_addr, .op_done
    );

    model_bram model_bram_i (
        .clk,
        .load_en, .load_idx, .load_data,
        .rd_en, .rd_idx, .rd_data
    );

    bram_line_reader bram_line_reader_i (
        .clk, .reset,
        .run_go, .run_cfg,
        .stall(line_alm_full),
        .rd_en, .rd_idx, .rd_valid
    );

    line_fifo #(.payload_t(line_t)) line_fifo_i (
        .clk, .reset,
        .push(rd_valid), .push_data(rd_data),
        .pop(line_pop), .pop_data(line_data),
        .empty(line_empty), .alm_full(line_alm_full)
    );

    write_sender write_sender_i (
        .clk, .reset,
        .sender_go, .base_addr,
        .line_empty, .line_data, .line_pop,
        .req_alm_full, .req_push, .req
    );

    line_fifo #(.payload_t(wr_req_t)) req_fifo_i (
        .clk, .reset,
        .push(req_push), .push_data(req),
        .pop(req_pop), .pop_data(req_head),
        .empty(req_empty), .alm_full(req_alm_full)
    );

    // The host sees no request in the cycle after it raised almost-full
    assign req_pop = !req_empty && !host_alm_full;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_valid <= 1'b0;
        end
        else
        begin
            wr_valid <= req_pop;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_pop)
        begin
            wr_req <= req_head;
        end
    end

endmodule

`default_nettype wire

// ==== dv/glm_store_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "glm_defines.svh"

module glm_store_sva
(
    input  logic clk,
    input  logic reset,
    input  logic op_done,
    input  logic wr_valid,
    input  logic host_alm_full,
    input  logic [1:0] ctrl_state
);

    // Encoding of the controller's idle state
    localparam logic [1:0] CTRL_IDLE = 2'd0;

    op_done_single: assert property (@(posedge clk) disable iff (reset)
        op_done |=> !op_done)
        else $error("op_done was high for two cycles in a row");

    // The host sees no request in the cycle after it raised almost-full
    no_valid_after_alm_full: assert property (@(posedge clk) disable iff (reset)
        host_alm_full |=> !wr_valid)
        else $error("wr_valid was high in the cycle after host_alm_full");

    no_valid_rise_when_idle: assert property (@(posedge clk) disable iff (reset)
        $rose(wr_valid) |-> (ctrl_state != CTRL_IDLE))
        else $error("wr_valid rose while the controller was idle");

endmodule

bind glm_store_top glm_store_sva glm_store_sva_i (
    .clk, .reset, .op_done, .wr_valid, .host_alm_full,
    .ctrl_state(store_controller_i.state)
);

`default_nettype wire

// ==== dv/glm_store_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "glm_defines.svh"

module glm_store_tb
    import glm_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 3000;

    logic clk;
    logic reset;
    logic op_start;
    store_cmd_t cmd;
    logic op_done;
    logic load_en;
    model_idx_t load_idx;
    line_t load_data;
    logic wr_valid;
    wr_req_t wr_req;
    logic host_alm_full;
    logic wr_ack;

    // Testbench copy of the model memory
    line_t model_copy [`GLM_MODEL_DEPTH];

    store_cmd_t cur_cmd;
    wr_req_t got_q [$];
    int ack_due_q [$];
    int cycle;
    int last_due;
    int req_seen;
    int acks_sent;
    int last_ack_cycle;
    logic busy;
    logic alm_mode;
    logic alm_prev;
    logic done_prev;
    logic [31:0] stim_rng;
    logic [31:0] host_rng;
    logic [31:0] alm_rng;

    glm_store_top glm_store_top_i (
        .clk, .reset,
        .op_start, .cmd, .op_done,
        .load_en, .load_idx, .load_data,
        .wr_valid, .wr_req, .host_alm_full, .wr_ack
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Request i goes to the selected base plus the signed offset plus i
    function automatic wr_req_t expected_req(input store_cmd_t c, input int i);
        wr_req_t r;
        longint base;
        longint offs;
        base = longint'(c.offset[31] ? c.in_addr : c.out_addr);
        offs = longint'($signed(c.offset));
        r.addr = addr_t'(base + offs + longint'(i));
        r.data = model_copy[(int'(c.model_start) + i) % `GLM_MODEL_DEPTH];
        return r;
    endfunction

    task automatic check_value(input string what, input logic [1023:0] got,
                               input logic [1023:0] exp);
        if (got !== exp)
        begin
            $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("STATUS: FAIL");
        $fatal(1, "Run aborted");
    endtask

    task automatic random_line(output line_t l);
        for (int w = 0; w < `GLM_LINE_BITS / 32; w++)
        begin
            stim_rng = lcg_step(stim_rng);
            l[w*32 +: 32] = stim_rng;
        end
    endtask

    task automatic random_addr(output addr_t a);
        logic [31:0] hi;
        stim_rng = lcg_step(stim_rng);
        hi = stim_rng;
        stim_rng = lcg_step(stim_rng);
        a = addr_t'({hi, stim_rng});
    endtask

    task automatic make_cmd(input logic use_in, input int len, output store_cmd_t c);
        addr_t a_in;
        addr_t a_out;
        random_addr(a_in);
        random_addr(a_out);
        c.in_addr = a_in;
        c.out_addr = a_out;
        stim_rng = lcg_step(stim_rng);
        c.offset = {use_in, stim_rng[30:0]};
        stim_rng = lcg_step(stim_rng);
        c.model_start = stim_rng[13:8];
        c.length = len_t'(len);
    endtask

    task automatic load_model();
        line_t l;
        for (int i = 0; i < `GLM_MODEL_DEPTH; i++)
        begin
            random_line(l);
            model_copy[i] = l;
            @(posedge clk);
            load_en <= 1'b1;
            load_idx <= model_idx_t'(i);
            load_data <= l;
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    // A nonzero stray_at pulses op_start with another command during the run
    task automatic run_store(input store_cmd_t c, input int stray_at, input int exp_latency);
        int lat;
        int acks_at_done;
        int ack_gap;
        logic seen;
        store_cmd_t stray;
        stray = c;
        stray.length = c.length + len_t'(5);
        stray.out_addr = ~c.out_addr;
        cur_cmd = c;
        req_seen = 0;
        acks_sent = 0;
        acks_at_done = 0;
        ack_gap = 0;
        @(posedge clk);
        busy = 1'b1;
        op_start <= 1'b1;
        cmd <= c;
        @(posedge clk);
        op_start <= 1'b0;
        lat = 1;
        seen = 1'b0;
        while (!seen)
        begin
            @(negedge clk);
            if (op_done)
            begin
                seen = 1'b1;
                acks_at_done = acks_sent;
                ack_gap = cycle - last_ack_cycle;
            end
            else
            begin
                @(posedge clk);
                lat++;
                if (lat == stray_at)
                begin
                    op_start <= 1'b1;
                    cmd <= stray;
                end
                else
                begin
                    op_start <= 1'b0;
                end
                if (lat > TIMEOUT_CYCLES)
                begin
                    abort_run("op_done never came for the store command");
                end
            end
        end
        @(posedge clk);
        op_start <= 1'b0;
        busy = 1'b0;
        check_value("request count", req_seen, c.length);
        check_value("acknowledgements before op_done", acks_at_done, c.length);
        if (c.length != '0)
        begin
            // op_done follows the last acknowledgement by one cycle
            check_value("cycles from last wr_ack to op_done", ack_gap, 1);
        end
        if (exp_latency > 0)
        begin
            check_value("op_done latency", lat, exp_latency);
        end
    endtask

    // Host memory accepts every valid request and acknowledges it later
    always @(posedge clk)
    begin : host_model
        int due;
        if (reset)
        begin
            wr_ack <= 1'b0;
        end
        else
        begin
            cycle++;
            if (wr_valid)
            begin
                got_q.push_back(wr_req);
                host_rng = lcg_step(host_rng);
                due = cycle + int'(host_rng[23:16] % 8'd7);
                if (due <= last_due)
                begin
                    due = last_due + 1;
                end
                last_due = due;
                ack_due_q.push_back(due);
            end
            if ((ack_due_q.size() > 0) && (ack_due_q[0] <= cycle))
            begin
                void'(ack_due_q.pop_front());
                acks_sent++;
                last_ack_cycle = cycle;
                wr_ack <= 1'b1;
            end
            else
            begin
                wr_ack <= 1'b0;
            end
        end
    end

    always @(posedge clk)
    begin
        if (alm_mode)
        begin
            alm_rng = lcg_step(alm_rng);
            host_alm_full <= (alm_rng[21:19] < 3'd3);
        end
        else
        begin
            host_alm_full <= 1'b0;
        end
    end

    always @(negedge clk)
    begin : compare_requests
        wr_req_t got;
        wr_req_t exp_req;
        while (got_q.size() > 0)
        begin
            if (req_seen >= int'(cur_cmd.length))
            begin
                abort_run("A write request arrived beyond the command length");
            end
            got = got_q.pop_front();
            exp_req = expected_req(cur_cmd, req_seen);
            check_value("request address", got.addr, exp_req.addr);
            check_value("request data", got.data, exp_req.data);
            req_seen++;
        end
    end

    // Protocol rules seen from the host side
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (wr_valid && alm_prev)
            begin
                abort_run("wr_valid came in the cycle after host almost-full");
            end
            if (op_done && done_prev)
            begin
                abort_run("op_done stayed high for two cycles");
            end
            if ((wr_valid || op_done) && !busy)
            begin
                abort_run("The DUT was active with no command running");
            end
        end
        alm_prev = host_alm_full;
        done_prev = op_done;
    end

    initial
    begin : main_sequence
        store_cmd_t c;
        int len;
        reset = 1'b1;
        op_start = 1'b0;
        cmd = '0;
        load_en = 1'b0;
        load_idx = '0;
        load_data = '0;
        host_alm_full = 1'b0;
        wr_ack = 1'b0;
        busy = 1'b0;
        alm_mode = 1'b0;
        alm_prev = 1'b0;
        done_prev = 1'b0;
        req_seen = 0;
        acks_sent = 0;
        last_ack_cycle = 0;
        cycle = 0;
        last_due = -1;
        stim_rng = 32'd55829;
        host_rng = 32'd55829;
        alm_rng = 32'd55829;

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        load_model();

        // Outputs must stay quiet before the first command
        repeat (10) @(posedge clk);

        stim_rng = lcg_step(stim_rng);
        len = 1 + int'(stim_rng[15:8] % 8'd16);
        make_cmd(1'b0, len, c);
        run_store(c, 0, 0);

        stim_rng = lcg_step(stim_rng);
        len = 1 + int'(stim_rng[15:8] % 8'd16);
        make_cmd(1'b1, len, c);
        run_store(c, 0, 0);

        make_cmd(1'b0, 0, c);
        run_store(c, 0, 2);

        // Long run under random host back-pressure
        alm_mode <= 1'b1;
        make_cmd(1'b1, 60, c);
        run_store(c, 0, 0);
        alm_mode <= 1'b0;

        make_cmd(1'b0, 12, c);
        run_store(c, 4, 0);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== glm_store_top.f ====
+incdir+hdl
hdl/glm_pkg.sv
hdl/model_bram.sv
hdl/line_fifo.sv
hdl/bram_line_reader.sv
hdl/store_controller.sv
hdl/write_sender.sv
hdl/glm_store_top.sv
dv/glm_store_sva.sv
dv/glm_store_tb.sv
